/* src/ifq_pkg.sv */
`default_nettype none

package ifq_pkg;

    localparam int INST_W   = 32;  // one instruction word.
    localparam int LANES    = 2;   // two-wide fetch and issue.
    localparam int FQ_DEPTH = 8;   // fetch queue entries.
    localparam int CSR_W    = 32;

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [LANES-1:0]  lane_mask_t;  // bit 0 is the older lane.
    typedef logic [1:0]        take_cnt_t;   // values 0 to 2.

    typedef logic [$clog2(FQ_DEPTH)-1:0] fq_ptr_t;
    typedef logic [$clog2(FQ_DEPTH):0]   fq_cnt_t;  // one extra bit so a full queue fits.

    typedef logic [1:0]       csr_addr_t;
    typedef logic [CSR_W-1:0] csr_data_t;

    // control register; bit 0 is single_issue.
    localparam csr_addr_t CSR_CTRL   = 2'd0;
    // issued-instruction counter; a write clears it.
    localparam csr_addr_t CSR_ISSUED = 2'd1;

endpackage

`default_nettype wire

/* src/fetch_queue.sv */
`default_nettype none

module fetch_queue (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic                   flush_i,

    input  wire logic                   push_valid_i,
    input  wire ifq_pkg::lane_mask_t    push_lanes_i,
    input  wire ifq_pkg::inst_t [1:0]   push_data_i,
    output logic                        push_ready_o,

    input  wire logic                   single_issue_i,

    output ifq_pkg::lane_mask_t         head_valid_o,
    output ifq_pkg::inst_t [1:0]        head_data_o,
    input  wire ifq_pkg::take_cnt_t     take_cnt_i
);

    ifq_pkg::inst_t mem_q [ifq_pkg::FQ_DEPTH];

    ifq_pkg::fq_ptr_t rd_ptr_q;
    ifq_pkg::fq_ptr_t wr_ptr_q;
    ifq_pkg::fq_cnt_t count_q;

    ifq_pkg::fq_ptr_t rd_ptr_p1;
    ifq_pkg::fq_ptr_t wr_ptr_p1;

    logic             push_fire;
    ifq_pkg::fq_cnt_t push_num;
    ifq_pkg::fq_cnt_t pop_num;
    ifq_pkg::take_cnt_t offer_cnt;

    assign rd_ptr_p1 = ifq_pkg::fq_ptr_t'(rd_ptr_q + 1'b1);
    assign wr_ptr_p1 = ifq_pkg::fq_ptr_t'(wr_ptr_q + 1'b1);

    // room for a full two-lane push is needed before accepting anything.
    assign push_ready_o = (count_q <= ifq_pkg::fq_cnt_t'(ifq_pkg::FQ_DEPTH - 2));
    assign push_fire    = push_valid_i & push_ready_o;

    always_comb begin
        push_num = '0;
        if (push_fire) begin
            push_num = ifq_pkg::fq_cnt_t'(push_lanes_i[0]) +
                       ifq_pkg::fq_cnt_t'(push_lanes_i[1]);
        end
    end

    assign pop_num = ifq_pkg::fq_cnt_t'(take_cnt_i);

    // offer the oldest word, and the next one only in two-wide mode.
    always_comb begin
        head_valid_o    = '0;
        head_valid_o[0] = (count_q != '0);
        head_valid_o[1] = (count_q >= ifq_pkg::fq_cnt_t'(2)) && !single_issue_i;
    end

    assign head_data_o[0] = mem_q[rd_ptr_q];
    assign head_data_o[1] = mem_q[rd_ptr_p1];

    assign offer_cnt = ifq_pkg::take_cnt_t'(head_valid_o[0]) +
                       ifq_pkg::take_cnt_t'(head_valid_o[1]);

    always_ff @(posedge clk) begin
        if (push_fire && push_lanes_i[0]) begin
            mem_q[wr_ptr_q] <= push_data_i[0];
        end
        if (push_fire && push_lanes_i[1]) begin
            mem_q[wr_ptr_p1] <= push_data_i[1];
        end
    end

    // a push in the flush cycle is wrong-path fetch and is dropped with the rest.
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= ifq_pkg::fq_ptr_t'(rd_ptr_q + pop_num);
            wr_ptr_q <= ifq_pkg::fq_ptr_t'(wr_ptr_q + push_num);
            count_q  <= count_q + push_num - pop_num;
        end
    end

    // the buffer may only retire words the queue actually offered.
    a_take_le_offer: assert property (
        @(posedge clk) disable iff (rst_i)
        take_cnt_i <= offer_cnt
    ) else $error("fetch_queue: take count %0d above offer %0d", take_cnt_i, offer_cnt);

    a_count_le_depth: assert property (
        @(posedge clk) disable iff (rst_i)
        count_q <= ifq_pkg::fq_cnt_t'(ifq_pkg::FQ_DEPTH)
    ) else $error("fetch_queue: occupancy %0d above depth", count_q);

endmodule

`default_nettype wire

/* src/issue_buffer.sv */
`default_nettype none

module issue_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic                   flush_i,

    input  wire ifq_pkg::lane_mask_t    in_valid_i,
    input  wire ifq_pkg::inst_t [1:0]   in_data_i,
    output ifq_pkg::take_cnt_t          take_cnt_o,

    output ifq_pkg::lane_mask_t         slot_valid_o,
    output ifq_pkg::inst_t [1:0]        slot_data_o,
    input  wire ifq_pkg::lane_mask_t    issue_i
);

    ifq_pkg::lane_mask_t     slot_valid_q;
    ifq_pkg::inst_t [1:0]    slot_data_q;

    ifq_pkg::lane_mask_t     slot_valid_d;
    ifq_pkg::inst_t [1:0]    slot_data_d;

    ifq_pkg::take_cnt_t      held_cnt;
    ifq_pkg::take_cnt_t      issued_cnt;
    ifq_pkg::take_cnt_t      keep_cnt;
    ifq_pkg::take_cnt_t      in_cnt;
    ifq_pkg::inst_t          keep_word;

    // the decoder sees nothing in a redirect cycle.
    assign slot_valid_o = slot_valid_q & {2{~flush_i}};
    assign slot_data_o  = slot_data_q;

    assign held_cnt   = ifq_pkg::take_cnt_t'(slot_valid_q[0]) +
                        ifq_pkg::take_cnt_t'(slot_valid_q[1]);
    assign issued_cnt = ifq_pkg::take_cnt_t'(issue_i[0]) +
                        ifq_pkg::take_cnt_t'(issue_i[1]);
    assign in_cnt     = ifq_pkg::take_cnt_t'(in_valid_i[0]) +
                        ifq_pkg::take_cnt_t'(in_valid_i[1]);
    assign keep_cnt   = held_cnt - issued_cnt;

    // after a single issue the survivor is slot 1, else it is still slot 0.
    assign keep_word = issue_i[0] ? slot_data_q[1] : slot_data_q[0];

    always_comb begin
        slot_valid_d = slot_valid_q;
        slot_data_d  = slot_data_q;
        take_cnt_o   = '0;
        case (keep_cnt)
            2'd0: begin
                slot_valid_d = in_valid_i;  // both slots free, take what is offered.
                slot_data_d  = in_data_i;
                take_cnt_o   = in_cnt;
            end
            2'd1: begin
                slot_valid_d   = {in_valid_i[0], 1'b1};
                slot_data_d[0] = keep_word;
                slot_data_d[1] = in_data_i[0];
                take_cnt_o     = ifq_pkg::take_cnt_t'(in_valid_i[0]);
            end
            default: begin
                slot_valid_d = slot_valid_q;  // full and stalled.
                slot_data_d  = slot_data_q;
                take_cnt_o   = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            slot_valid_q <= '0;
        end else begin
            slot_valid_q <= slot_valid_d;
        end
        slot_data_q <= slot_data_d;
    end

    // slot 1 can never go ahead of slot 0.
    a_issue_in_order: assert property (
        @(posedge clk) disable iff (rst_i)
        issue_i != 2'b10
    ) else $error("issue_buffer: slot 1 issued without slot 0");

    a_issue_valid_only: assert property (
        @(posedge clk) disable iff (rst_i)
        (issue_i & ~slot_valid_o) == '0
    ) else $error("issue_buffer: issue %b over slots %b", issue_i, slot_valid_o);

endmodule

`default_nettype wire

/* src/frontend_csr.sv */
`default_nettype none

module frontend_csr (
    input  wire logic                   clk,
    input  wire logic                   rst_i,

    input  wire logic                   csr_we_i,
    input  wire ifq_pkg::csr_addr_t     csr_addr_i,
    input  wire ifq_pkg::csr_data_t     csr_wdata_i,
    output ifq_pkg::csr_data_t          csr_rdata_o,

    output logic                        single_issue_o,

    input  wire ifq_pkg::lane_mask_t    slot_valid_i,
    input  wire ifq_pkg::lane_mask_t    issue_i,
    input  wire logic                   flush_i
);

    logic                 single_issue_q;
    ifq_pkg::csr_data_t   issued_q;
    ifq_pkg::lane_mask_t  issued_lanes;
    ifq_pkg::csr_data_t   issued_inc;
    logic                 wr_ctrl;
    logic                 wr_issued;

    assign single_issue_o = single_issue_q;

    assign wr_ctrl   = csr_we_i && (csr_addr_i == ifq_pkg::CSR_CTRL);
    assign wr_issued = csr_we_i && (csr_addr_i == ifq_pkg::CSR_ISSUED);

    // words leaving the buffer this cycle.
    assign issued_lanes = issue_i & slot_valid_i;
    assign issued_inc   = ifq_pkg::csr_data_t'(issued_lanes[0]) +
                          ifq_pkg::csr_data_t'(issued_lanes[1]);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            single_issue_q <= 1'b0;
        end else if (wr_ctrl) begin
            single_issue_q <= csr_wdata_i[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issued_q <= '0;
        end else if (wr_issued) begin
            issued_q <= '0;  // software clear beats a same-cycle issue.
        end else if (!flush_i) begin
            issued_q <= issued_q + issued_inc;
        end
    end

    always_comb begin
        case (csr_addr_i)
            ifq_pkg::CSR_CTRL: begin
                csr_rdata_o = ifq_pkg::csr_data_t'(single_issue_q);
            end
            ifq_pkg::CSR_ISSUED: begin
                csr_rdata_o = issued_q;
            end
            default: begin
                csr_rdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/frontend_top.sv */
`default_nettype none

module frontend_top (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic                   flush_i,

    // fetch unit push side.
    input  wire logic                   push_valid_i,
    input  wire ifq_pkg::lane_mask_t    push_lanes_i,
    input  wire ifq_pkg::inst_t [1:0]   push_data_i,
    output logic                        push_ready_o,

    // decoder side.
    output ifq_pkg::lane_mask_t         slot_valid_o,
    output ifq_pkg::inst_t [1:0]        slot_data_o,
    input  wire ifq_pkg::lane_mask_t    issue_i,

    // register access.
    input  wire logic                   csr_we_i,
    input  wire ifq_pkg::csr_addr_t     csr_addr_i,
    input  wire ifq_pkg::csr_data_t     csr_wdata_i,
    output ifq_pkg::csr_data_t          csr_rdata_o
);

    ifq_pkg::lane_mask_t   head_valid;
    ifq_pkg::inst_t [1:0]  head_data;
    ifq_pkg::take_cnt_t    take_cnt;
    logic                  single_issue;

    fetch_queue fq0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .push_valid_i   (push_valid_i),
        .push_lanes_i   (push_lanes_i),
        .push_data_i    (push_data_i),
        .push_ready_o   (push_ready_o),
        .single_issue_i (single_issue),
        .head_valid_o   (head_valid),
        .head_data_o    (head_data),
        .take_cnt_i     (take_cnt)
    );

    issue_buffer ib0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .in_valid_i   (head_valid),
        .in_data_i    (head_data),
        .take_cnt_o   (take_cnt),
        .slot_valid_o (slot_valid_o),
        .slot_data_o  (slot_data_o),
        .issue_i      (issue_i)
    );

    // the counter watches the masked slot valids, so flush cycles count nothing.
    frontend_csr csr0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .csr_we_i       (csr_we_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .single_issue_o (single_issue),
        .slot_valid_i   (slot_valid_o),
        .issue_i        (issue_i),
        .flush_i        (flush_i)
    );

endmodule

`default_nettype wire

/* sim/frontend_tb_ref.svh */
`ifndef FRONTEND_TB_REF_SVH
`define FRONTEND_TB_REF_SVH

ifq_pkg::inst_t model_q[$];  // every word between push port and decoder, oldest first.
int unsigned    exp_issued;
logic           exp_single;

function automatic int lane_count(input ifq_pkg::lane_mask_t mask);
    return int'(mask[0]) + int'(mask[1]);
endfunction

function automatic ifq_pkg::inst_t oldest_word();
    return model_q[0];
endfunction

// words that are not in a slot sit in the queue, which accepts only with two entries free.
function automatic logic expected_ready(input int held);
    return (model_q.size() - held) <= (ifq_pkg::FQ_DEPTH - 2);
endfunction

function automatic ifq_pkg::csr_data_t expected_csr(input ifq_pkg::csr_addr_t addr);
    ifq_pkg::csr_data_t value;
    value = '0;
    if (addr == ifq_pkg::CSR_CTRL) begin
        value = ifq_pkg::csr_data_t'(exp_single);
    end else if (addr == ifq_pkg::CSR_ISSUED) begin
        value = exp_issued;
    end
    return value;
endfunction

task automatic report_failure(input string what);
    $display("%s (at %0t)", what, $time);
    $display("Simulation finished: FAIL");
    $fatal(1, "frontend_tb stopped");
endtask

task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1, "frontend_tb stopped");
    end
endtask

`endif

/* sim/frontend_tb.sv */
`default_nettype none

module frontend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAND_CYCLES    = 300;
    localparam int BURST_CYCLES   = 120;
    localparam int SINGLE_CYCLES  = 120;
    localparam int WIDE_CYCLES    = 60;
    localparam int FLUSH_CYCLES   = 150;
    localparam int DRAIN_LIMIT    = 40;
    localparam int PLANNED_CYCLES = 16 + RAND_CYCLES + BURST_CYCLES + SINGLE_CYCLES +
                                    WIDE_CYCLES + FLUSH_CYCLES + 5 * DRAIN_LIMIT + 20;

    localparam int ISSUE_NONE   = 0;
    localparam int ISSUE_ONE    = 1;
    localparam int ISSUE_RANDOM = 2;
    localparam int ISSUE_ALL    = 3;

    logic                 clk;
    logic                 rst_i;
    logic                 flush_i;
    logic                 push_valid_i;
    ifq_pkg::lane_mask_t  push_lanes_i;
    ifq_pkg::inst_t [1:0] push_data_i;
    logic                 push_ready_o;
    ifq_pkg::lane_mask_t  slot_valid_o;
    ifq_pkg::inst_t [1:0] slot_data_o;
    ifq_pkg::lane_mask_t  issue_i;
    logic                 csr_we_i;
    ifq_pkg::csr_addr_t   csr_addr_i;
    ifq_pkg::csr_data_t   csr_wdata_i;
    ifq_pkg::csr_data_t   csr_rdata_o;

    logic        push_fired;  // last push was taken at the edge.
    int unsigned word_seq;
    logic        saw_full;
    logic        saw_two_wide;

    `include "frontend_tb_ref.svh"

    frontend_top dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid_i),
        .push_lanes_i (push_lanes_i),
        .push_data_i  (push_data_i),
        .push_ready_o (push_ready_o),
        .slot_valid_o (slot_valid_o),
        .slot_data_o  (slot_data_o),
        .issue_i      (issue_i),
        .csr_we_i     (csr_we_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_rdata_o  (csr_rdata_o)
    );

    always #10 clk = ~clk;

    task automatic drive_cycle(input int push_pct, input int issue_mode, input logic do_flush);
        ifq_pkg::lane_mask_t seen;
        int unsigned pick;
        @(posedge clk);
        #2;
        seen     = slot_valid_o;  // read before flush_i can mask it.
        flush_i  = do_flush;
        csr_we_i = 1'b0;
        if (!(push_valid_i && !push_fired)) begin
            push_valid_i   = ($urandom_range(99, 0) < push_pct);
            push_lanes_i   = $urandom_range(1, 0) ? 2'b11 : 2'b01;
            push_data_i[0] = {16'($urandom()), 16'(word_seq)};
            push_data_i[1] = {16'($urandom()), 16'(word_seq + 1)};
            word_seq += 2;
        end
        pick    = $urandom_range(2, 0);
        issue_i = 2'b00;
        if (!do_flush && seen[0]) begin
            case (issue_mode)
                ISSUE_ONE:    issue_i = (pick != 0) ? 2'b01 : 2'b00;
                ISSUE_RANDOM: issue_i = (pick == 2) ? {seen[1], 1'b1} : {1'b0, pick == 1};
                ISSUE_ALL:    issue_i = seen;
                default:      issue_i = 2'b00;
            endcase
        end
        if (!push_ready_o) saw_full = 1'b1;
        if (dut0.head_valid == 2'b11) saw_two_wide = 1'b1;
    endtask

    task automatic write_csr(input ifq_pkg::csr_addr_t addr, input ifq_pkg::csr_data_t data);
        drive_cycle(0, ISSUE_NONE, 1'b0);
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
    endtask

    task automatic read_csr(input ifq_pkg::csr_addr_t addr, input string name);
        drive_cycle(0, ISSUE_NONE, 1'b0);
        csr_addr_i = addr;
        #1;
        check_equal(name, csr_rdata_o, expected_csr(addr));
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (model_q.size() != 0) begin
            if (n == DRAIN_LIMIT) report_failure("words were left in flight after draining");
            drive_cycle(0, ISSUE_ALL, 1'b0);
            n++;
        end
    endtask

    always @(negedge clk) begin : compare
        int held;
        int issued_now;
        issued_now = 0;
        push_fired = !rst_i && push_valid_i && push_ready_o;
        if (!rst_i && flush_i) begin
            check_equal("slot_valid_o", slot_valid_o, '0);
            model_q.delete();  // a push in the flush cycle is dropped too.
        end else if (!rst_i) begin
            held = lane_count(slot_valid_o);
            if (slot_valid_o == 2'b10) report_failure("slot 1 is valid while slot 0 is empty");
            if (held > model_q.size()) report_failure("the buffer shows words never pushed");
            check_equal("push_ready_o", push_ready_o, expected_ready(held));
            if (exp_single) check_equal("head_valid[1]", dut0.head_valid[1], 1'b0);
            if (slot_valid_o[0]) check_equal("slot_data_o[0]", slot_data_o[0], oldest_word());
            if (issue_i[0] && slot_valid_o[0]) begin
                void'(model_q.pop_front());
                issued_now++;
            end
            if (issue_i[1] && slot_valid_o[1]) begin
                check_equal("slot_data_o[1]", slot_data_o[1], oldest_word());
                void'(model_q.pop_front());
                issued_now++;
            end
            if (push_fired && push_lanes_i[0]) model_q.push_back(push_data_i[0]);
            if (push_fired && push_lanes_i[1]) model_q.push_back(push_data_i[1]);
        end
        if (!rst_i && csr_we_i && csr_addr_i == ifq_pkg::CSR_ISSUED) begin
            exp_issued = 0;
        end else begin
            exp_issued += issued_now;
        end
        if (!rst_i && csr_we_i && csr_addr_i == ifq_pkg::CSR_CTRL) exp_single = csr_wdata_i[0];
    end

    initial begin : watchdog
        #(PLANNED_CYCLES * 20 + 2000);
        report_failure("watchdog: the run did not finish in the planned time");
    end

    initial begin
        void'($urandom(48));
        clk          = 1'b0;
        rst_i        = 1'b1;
        flush_i      = 1'b0;
        push_valid_i = 1'b0;
        push_lanes_i = '0;
        push_data_i  = '0;
        issue_i      = '0;
        csr_we_i     = 1'b0;
        csr_addr_i   = ifq_pkg::CSR_CTRL;
        csr_wdata_i  = '0;
        push_fired   = 1'b0;
        word_seq     = 0;
        saw_full     = 1'b0;
        saw_two_wide = 1'b0;
        exp_issued   = 0;
        exp_single   = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_i = 1'b0;

        check_equal("slot_valid_o", slot_valid_o, '0);
        check_equal("push_ready_o", push_ready_o, 1'b1);
        read_csr(ifq_pkg::CSR_CTRL, "csr_rdata_o ctrl");
        read_csr(ifq_pkg::CSR_ISSUED, "csr_rdata_o issued");

        for (int i = 0; i < RAND_CYCLES; i++) begin
            drive_cycle(80, (i % 100 < 30) ? ISSUE_NONE : ISSUE_RANDOM, 1'b0);
        end
        if (!saw_full) report_failure("the queue never filled under back-pressure");
        drain();

        for (int i = 0; i < BURST_CYCLES; i++) begin
            drive_cycle(60, ISSUE_ONE, 1'b0);
        end
        drain();

        write_csr(ifq_pkg::CSR_CTRL, 32'h1);
        read_csr(ifq_pkg::CSR_CTRL, "csr_rdata_o ctrl");
        for (int i = 0; i < SINGLE_CYCLES; i++) begin
            drive_cycle(70, ISSUE_RANDOM, 1'b0);
        end
        drain();
        write_csr(ifq_pkg::CSR_CTRL, 32'h0);
        saw_two_wide = 1'b0;
        for (int i = 0; i < WIDE_CYCLES; i++) begin
            drive_cycle(90, ISSUE_ALL, 1'b0);
        end
        if (!saw_two_wide) report_failure("two-wide delivery did not return");
        drain();

        for (int i = 0; i < FLUSH_CYCLES; i++) begin
            drive_cycle(80, ISSUE_RANDOM, (i == 60) || ($urandom_range(99, 0) < 4));
        end
        drain();

        read_csr(ifq_pkg::CSR_ISSUED, "csr_rdata_o issued");
        if (exp_issued == 0) report_failure("no issued instructions were counted");
        write_csr(ifq_pkg::CSR_ISSUED, 32'h0);
        read_csr(ifq_pkg::CSR_ISSUED, "csr_rdata_o issued");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+sim
src/ifq_pkg.sv
src/fetch_queue.sv
src/issue_buffer.sv
src/frontend_csr.sv
src/frontend_top.sv
sim/frontend_tb.sv

/* Bender.yml */
package:
  name: frontend_ifq

sources:
  - files:
      - src/ifq_pkg.sv
      - src/fetch_queue.sv
      - src/issue_buffer.sv
      - src/frontend_csr.sv
      - src/frontend_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/frontend_tb.sv
